//--- stage3_cnn_pkg.sv
package stage3_cnn_pkg;

    ////////////////////
    // Data path widths
    ////////////////////

    // Channel and class counts
    localparam int CI = 4;
    localparam int CO = 3;

    // Unsigned activation paths
    localparam int IF_BW  = 8;
    localparam int OF_BW  = 8;
    localparam int ACC_BW = 16;

    // Signed scoring path
    localparam int OUT_BW = 24;
    localparam int W_BW   = 8;

    ////////////////////
    // Vector types
    ////////////////////

    typedef logic signed [W_BW-1:0]   weight_t;
    typedef logic signed [OUT_BW-1:0] score_t;

    typedef logic [CI-1:0][IF_BW-1:0]  if_vec_t;
    typedef logic [CI-1:0][OF_BW-1:0]  of_vec_t;
    typedef logic [CI-1:0][ACC_BW-1:0] acc_vec_t;

    // Elements keep their sign through the named element type
    typedef score_t [CO-1:0] score_vec_t;

    ////////////////////
    // Fixed classifier
    ////////////////////

    // One row per class, one column per input channel
    // Each class favors its own channel, channel 3 leans to classes 1 and 2
    localparam weight_t CLASS_WEIGHTS [CO][CI] = '{
        '{ 6, -2, -2,  1},
        '{-2,  6, -2,  2},
        '{-2, -2,  6,  2}
    };

    // Equal bias on classes 1 and 2 so matching inputs tie
    localparam score_t CLASS_BIAS [CO] = '{0, 10, 10};

    // ASCII 'a' for class 0
    localparam logic [7:0] ALPHA_BASE = 8'h61;

endpackage

//--- stage3_max_pooling.sv
`timescale 1ns/1ns

module stage3_max_pooling #(
    parameter int POOL_LEN = 2
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    i_relu_valid,
    input  stage3_cnn_pkg::if_vec_t i_in_relu,
    output logic                    o_ot_valid,
    output stage3_cnn_pkg::of_vec_t o_ot_pool
);
    import stage3_cnn_pkg::*;

    // Wide enough to hold the group length itself
    localparam int CNT_BW = $clog2(POOL_LEN + 1);

    logic [CNT_BW-1:0] beat_cnt;
    of_vec_t           max_q;
    of_vec_t           max_d;
    logic              last_beat;

    // Final beat of the current pooling group
    assign last_beat = i_relu_valid && (beat_cnt == CNT_BW'(POOL_LEN - 1));

    // Running maximum including the current beat
    always_comb begin
        for (int ch = 0; ch < CI; ch++) begin
            if (i_in_relu[ch] > max_q[ch]) begin
                max_d[ch] = i_in_relu[ch];
            end else begin
                max_d[ch] = max_q[ch];
            end
        end
    end

    ////////////////////
    // Group tracking
    ////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            beat_cnt   <= '0;
            max_q      <= '0;
            o_ot_pool  <= '0;
            o_ot_valid <= 1'b0;
        end else begin
            o_ot_valid <= last_beat;
            if (last_beat) begin
                // Zero is neutral for unsigned ReLU data
                beat_cnt  <= '0;
                max_q     <= '0;
                o_ot_pool <= max_d;
            end else if (i_relu_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
                max_q    <= max_d;
            end
        end
    end

    // Counter wraps before it can reach the group length
    a_beat_cnt_range : assert property (
        @(posedge clk) disable iff (!reset_n)
        int'(beat_cnt) < POOL_LEN
    );

endmodule

//--- stage3_cnn_acc_ci.sv
`timescale 1ns/1ns

module stage3_cnn_acc_ci #(
    parameter int FRAME_LEN = 4
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     i_in_valid,
    input  stage3_cnn_pkg::of_vec_t  i_in_pooling,
    output logic                     o_ot_valid,
    output stage3_cnn_pkg::acc_vec_t o_ot_ci_acc
);
    import stage3_cnn_pkg::*;

    localparam int CNT_BW = $clog2(FRAME_LEN);

    logic [CNT_BW-1:0] vec_cnt;
    acc_vec_t          acc_q;
    acc_vec_t          acc_d;
    logic              last_vec;

    assign last_vec = i_in_valid && (vec_cnt == CNT_BW'(FRAME_LEN - 1));

    // Partial sums with the incoming pooled vector
    always_comb begin
        for (int ch = 0; ch < CI; ch++) begin
            acc_d[ch] = acc_q[ch] + ACC_BW'(i_in_pooling[ch]);
        end
    end

    ////////////////////
    // Frame buffer
    ////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vec_cnt     <= '0;
            acc_q       <= '0;
            o_ot_ci_acc <= '0;
            o_ot_valid  <= 1'b0;
        end else begin
            o_ot_valid <= last_vec;
            if (last_vec) begin
                // Totals leave, next frame starts from zero
                vec_cnt     <= '0;
                acc_q       <= '0;
                o_ot_ci_acc <= acc_d;
            end else if (i_in_valid) begin
                vec_cnt <= vec_cnt + 1'b1;
                acc_q   <= acc_d;
            end
        end
    end

    // A frame spans at least two pooled vectors
    a_no_back_to_back : assert property (
        @(posedge clk) disable iff (!reset_n)
        o_ot_valid |=> !o_ot_valid
    );

endmodule

//--- stage3_cnn_core.sv
`timescale 1ns/1ns

module stage3_cnn_core (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       i_in_valid,
    input  stage3_cnn_pkg::acc_vec_t   i_in_ci_acc,
    output logic                       o_ot_valid,
    output stage3_cnn_pkg::score_vec_t o_ot_result
);
    import stage3_cnn_pkg::*;

    // Zero-extended total times signed weight
    localparam int PROD_BW = ACC_BW + 1 + W_BW;
    // Room for CI products plus the bias
    localparam int SUM_BW  = PROD_BW + $clog2(CI) + 1;

    localparam logic signed [SUM_BW-1:0] SCORE_MAX = 2 ** (OUT_BW - 1) - 1;
    localparam logic signed [SUM_BW-1:0] SCORE_MIN = -(2 ** (OUT_BW - 1));

    logic [1:0]                valid_q;
    logic signed [PROD_BW-1:0] prod_q [CO][CI];
    logic signed [SUM_BW-1:0]  sum_d [CO];
    score_vec_t                result_q;

    // Strobe follows the data through both stages
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[0], i_in_valid};
        end
    end

    ////////////////////
    // Stage 1 products
    ////////////////////

    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            for (int co = 0; co < CO; co++) begin
                for (int ci = 0; ci < CI; ci++) begin
                    prod_q[co][ci] <= $signed({1'b0, i_in_ci_acc[ci]}) * CLASS_WEIGHTS[co][ci];
                end
            end
        end
    end

    ////////////////////
    // Stage 2 sums
    ////////////////////

    always_comb begin
        for (int co = 0; co < CO; co++) begin
            sum_d[co] = SUM_BW'(CLASS_BIAS[co]);
            for (int ci = 0; ci < CI; ci++) begin
                sum_d[co] = sum_d[co] + SUM_BW'(prod_q[co][ci]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_q[0]) begin
            for (int co = 0; co < CO; co++) begin
                result_q[co] <= sum_d[co][OUT_BW-1:0];
            end
        end
    end

    assign o_ot_valid  = valid_q[1];
    assign o_ot_result = result_q;

    // Scores must fit the output width before the upper bits are dropped
    for (genvar co = 0; co < CO; co++) begin : g_range_chk
        a_score_range : assert property (
            @(posedge clk) disable iff (!reset_n)
            valid_q[0] |-> (sum_d[co] >= SCORE_MIN) && (sum_d[co] <= SCORE_MAX)
        );
    end

endmodule

//--- stage3_compare_alpha.sv
`timescale 1ns/1ns

module stage3_compare_alpha (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       i_in_valid,
    input  stage3_cnn_pkg::score_vec_t i_in_scores,
    output logic [7:0]                 o_alpha,
    output logic                       o_valid
);
    import stage3_cnn_pkg::*;

    localparam int IDX_BW = $clog2(CO);

    score_vec_t        score_q;
    logic [IDX_BW-1:0] best_idx;

    // Scores held until the next frame
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            score_q <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_in_valid;
            if (i_in_valid) begin
                score_q <= i_in_scores;
            end
        end
    end

    // Strict compare keeps the lower index on a tie
    always_comb begin
        best_idx = '0;
        for (int i = 1; i < CO; i++) begin
            if (score_q[i] > score_q[best_idx]) begin
                best_idx = IDX_BW'(i);
            end
        end
    end

    assign o_alpha = ALPHA_BASE + 8'(best_idx);

    a_alpha_range : assert property (
        @(posedge clk) disable iff (!reset_n)
        o_valid |-> (o_alpha >= ALPHA_BASE) && (o_alpha <= ALPHA_BASE + 8'(CO - 1))
    );

endmodule

//--- stage3_top_cnn.sv
`timescale 1ns/1ns

module stage3_top_cnn #(
    parameter int POOL_LEN  = 2,
    parameter int FRAME_LEN = 4
) (
    input  logic                                                 clk,
    input  logic                                                 reset_n,
    input  logic                                                 i_relu_valid,
    input  logic [stage3_cnn_pkg::CI*stage3_cnn_pkg::IF_BW-1:0]  i_in_relu,
    output logic                                                 o_valid,
    output logic [7:0]                                           o_alpha
);
    import stage3_cnn_pkg::*;

    logic       pool_valid;
    of_vec_t    pool_vec;
    logic       acc_valid;
    acc_vec_t   acc_vec;
    logic       core_valid;
    score_vec_t core_scores;

    ////////////////////
    // Pooling and frame
    ////////////////////

    stage3_max_pooling #(
        .POOL_LEN (POOL_LEN)
    ) u_stage3_max_pooling (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_relu_valid (i_relu_valid),
        .i_in_relu    (i_in_relu),
        .o_ot_valid   (pool_valid),
        .o_ot_pool    (pool_vec)
    );

    stage3_cnn_acc_ci #(
        .FRAME_LEN (FRAME_LEN)
    ) u_stage3_cnn_acc_ci (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_in_valid   (pool_valid),
        .i_in_pooling (pool_vec),
        .o_ot_valid   (acc_valid),
        .o_ot_ci_acc  (acc_vec)
    );

    ////////////////////
    // Scoring and result
    ////////////////////

    stage3_cnn_core u_stage3_cnn_core (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_in_valid  (acc_valid),
        .i_in_ci_acc (acc_vec),
        .o_ot_valid  (core_valid),
        .o_ot_result (core_scores)
    );

    stage3_compare_alpha u_stage3_compare_alpha (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_in_valid  (core_valid),
        .i_in_scores (core_scores),
        .o_alpha     (o_alpha),
        .o_valid     (o_valid)
    );

endmodule

//--- tb_stage3_top_cnn.sv
`timescale 1ns/1ns

module tb_stage3_top_cnn;
    import stage3_cnn_pkg::*;

    localparam int POOL_LEN    = 2;
    localparam int FRAME_LEN   = 4;
    localparam int FRAME_BEATS = POOL_LEN * FRAME_LEN;
    localparam int CLK_PERIOD  = 40;
    localparam int LATENCY     = 5;
    localparam int MAX_GAP     = 3;
    localparam int N_DIRECTED  = 5;
    localparam int N_GAP_PAIRS = 4;
    localparam int N_RANDOM    = 8;
    localparam int N_ENTRY     = N_DIRECTED + 2 * N_GAP_PAIRS + N_RANDOM;
    localparam int WATCHDOG_CYCLES = N_ENTRY * (FRAME_BEATS * (1 + MAX_GAP) + 20);

    logic       clk;
    logic       reset_n;
    logic       i_relu_valid;
    if_vec_t    i_in_relu;
    logic       o_valid;
    logic [7:0] o_alpha;

    // Stimulus table, one frame per entry
    if_vec_t    tbl_beats [N_ENTRY][FRAME_BEATS];
    int         tbl_gap [N_ENTRY][FRAME_BEATS];
    logic [7:0] tbl_letter [N_ENTRY];

    logic [7:0] exp_letter_q [$];
    int         exp_cycle_q [$];
    integer     seed;
    int         cycle = 0;
    int         value_errors = 0;
    int         protocol_errors = 0;
    logic       seen_valid = 1'b0;

    stage3_top_cnn #(
        .POOL_LEN  (POOL_LEN),
        .FRAME_LEN (FRAME_LEN)
    ) stage3_top_cnn_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_relu_valid (i_relu_valid),
        .i_in_relu    (i_in_relu),
        .o_valid      (o_valid),
        .o_alpha      (o_alpha)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic [7:0] model_letter(input int idx);
        int total [CI];
        int pmax;
        int score;
        int best_score;
        int best;
        for (int ch = 0; ch < CI; ch++) begin
            total[ch] = 0;
            for (int g = 0; g < FRAME_LEN; g++) begin
                pmax = 0;
                for (int k = 0; k < POOL_LEN; k++) begin
                    if (int'(tbl_beats[idx][g * POOL_LEN + k][ch]) > pmax) begin
                        pmax = int'(tbl_beats[idx][g * POOL_LEN + k][ch]);
                    end
                end
                total[ch] += pmax;
            end
        end
        best = 0;
        best_score = 0;
        for (int co = 0; co < CO; co++) begin
            score = int'(CLASS_BIAS[co]);
            for (int ch = 0; ch < CI; ch++) begin
                score += int'(CLASS_WEIGHTS[co][ch]) * total[ch];
            end
            // Strict compare, lowest class wins a tie
            if (co == 0 || score > best_score) begin
                best_score = score;
                best = co;
            end
        end
        return ALPHA_BASE + 8'(best);
    endfunction

    ////////////////////
    // Table setup
    ////////////////////

    // Same pair of beats repeated over the whole frame
    task automatic load_frame(input int idx, input if_vec_t first, input if_vec_t second,
                              input logic [7:0] letter);
        for (int b = 0; b < FRAME_BEATS; b++) begin
            tbl_beats[idx][b] = (b % POOL_LEN == 0) ? first : second;
            tbl_gap[idx][b] = 0;
        end
        tbl_letter[idx] = letter;
    endtask

    task automatic build_table();
        int idx;
        // Vectors are {ch3, ch2, ch1, ch0}
        load_frame(0, {8'd0, 8'd0, 8'd0, 8'd100}, {8'd0, 8'd0, 8'd0, 8'd100}, "a");
        load_frame(1, {8'd0, 8'd0, 8'd100, 8'd0}, {8'd0, 8'd0, 8'd100, 8'd0}, "b");
        load_frame(2, {8'd0, 8'd100, 8'd0, 8'd0}, {8'd0, 8'd100, 8'd0, 8'd0}, "c");
        // Max gives a, last beat or pair sum would give b
        load_frame(3, {8'd0, 8'd0, 8'd140, 8'd200}, {8'd0, 8'd0, 8'd130, 8'd10}, "a");
        // Classes 1 and 2 score the same
        load_frame(4, {8'd40, 8'd50, 8'd50, 8'd0}, {8'd40, 8'd50, 8'd50, 8'd0}, "b");
        // Gapped frame followed by the same data without gaps
        for (int p = 0; p < N_GAP_PAIRS; p++) begin
            idx = N_DIRECTED + 2 * p;
            for (int b = 0; b < FRAME_BEATS; b++) begin
                tbl_beats[idx][b] = $random(seed);
                tbl_gap[idx][b] = $unsigned($random(seed)) % (MAX_GAP + 1);
                tbl_beats[idx + 1][b] = tbl_beats[idx][b];
                tbl_gap[idx + 1][b] = 0;
            end
        end
        for (int r = 0; r < N_RANDOM; r++) begin
            idx = N_DIRECTED + 2 * N_GAP_PAIRS + r;
            for (int b = 0; b < FRAME_BEATS; b++) begin
                tbl_beats[idx][b] = $random(seed);
                tbl_gap[idx][b] = 0;
            end
        end
        for (int k = N_DIRECTED; k < N_ENTRY; k++) begin
            tbl_letter[k] = model_letter(k);
        end
    endtask

    ////////////////////
    // Drive and check
    ////////////////////

    task automatic send_frame(input int idx);
        for (int b = 0; b < FRAME_BEATS; b++) begin
            @(negedge clk);
            i_relu_valid = 1'b1;
            i_in_relu = tbl_beats[idx][b];
            if (b == FRAME_BEATS - 1) begin
                exp_letter_q.push_back(tbl_letter[idx]);
                exp_cycle_q.push_back(cycle);
            end
            for (int g = 0; g < tbl_gap[idx][b]; g++) begin
                @(negedge clk);
                i_relu_valid = 1'b0;
                // Junk on idle cycles must be ignored
                i_in_relu = $random(seed);
            end
        end
    endtask

    task automatic check_alpha(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("error %0t: o_alpha is %c (%h), expected %c (%h)", $time, got, got, exp, exp);
            value_errors++;
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("error %0t: o_valid after %0d cycles, expected %0d", $time, got, exp);
            value_errors++;
        end
    endtask

    always @(negedge clk) begin
        if (reset_n) begin
            if (o_valid) begin
                seen_valid = 1'b1;
                if (exp_letter_q.size() == 0) begin
                    $display("o_valid pulsed at %0t while no frame was outstanding", $time);
                    protocol_errors++;
                end else begin
                    check_alpha(o_alpha, exp_letter_q.pop_front());
                    check_latency(cycle - exp_cycle_q.pop_front(), LATENCY);
                end
            end else begin
                if (!seen_valid) begin
                    check_alpha(o_alpha, ALPHA_BASE);
                end
                if (exp_cycle_q.size() != 0 && cycle - exp_cycle_q[0] > LATENCY) begin
                    $display("o_valid never came for a frame completed at cycle %0d",
                             exp_cycle_q[0]);
                    protocol_errors++;
                    void'(exp_letter_q.pop_front());
                    void'(exp_cycle_q.pop_front());
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        reset_n = 1'b0;
        i_relu_valid = 1'b0;
        i_in_relu = '0;
        seed = 64;
        build_table();
        // Ten full clock cycles in reset, released on a falling edge
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        // Idle cycles where o_alpha must already read a
        repeat (4) @(negedge clk);
        for (int k = 0; k < N_ENTRY; k++) begin
            send_frame(k);
        end
        @(negedge clk);
        i_relu_valid = 1'b0;
        i_in_relu = '0;
        repeat (2 * LATENCY) @(negedge clk);
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- flist.f
stage3_cnn_pkg.sv
stage3_max_pooling.sv
stage3_cnn_acc_ci.sv
stage3_cnn_core.sv
stage3_compare_alpha.sv
stage3_top_cnn.sv
tb_stage3_top_cnn.sv

//--- Bender.yml
package:
  name: stage3_cnn

sources:
  - stage3_cnn_pkg.sv
  - stage3_max_pooling.sv
  - stage3_cnn_acc_ci.sv
  - stage3_cnn_core.sv
  - stage3_compare_alpha.sv
  - stage3_top_cnn.sv
  - target: simulation
    files:
      - tb_stage3_top_cnn.sv
